// File: src/alu_pkg.sv
// Shared types for the pipelined accumulator ALU
// Word width is fixed at 32, float ops touch the sign bit only
// Opcode values match the original ALU encoding, gaps are undefined

package alu_pkg;

	// ******************************
	// Word
	// ******************************

	localparam int alu_w = 32;

	typedef logic signed [alu_w-1:0] alu_word_t;   // Operands and results

	// ******************************
	// Opcodes
	// ******************************

	typedef enum logic [5:0] {
		NOP     = 6'd0,     // Returns in2
		LOD     = 6'd1,     // Returns in1
		ADD     = 6'd2,
		MLT     = 6'd4,     // Low half of product
		SGN     = 6'd9,     // in2 with sign taken from in1
		NEG     = 6'd11,
		NEG_M   = 6'd12,
		F_NEG   = 6'd13,
		F_NEG_M = 6'd14,
		ABS     = 6'd15,
		ABS_M   = 6'd16,
		F_ABS   = 6'd17,
		F_ABS_M = 6'd18,
		PST     = 6'd19,    // Clamp negatives to zero
		PST_M   = 6'd20,
		NRM     = 6'd23,    // Divide by constant gain
		NRM_M   = 6'd24,
		AND     = 6'd29,
		ORR     = 6'd30,
		XOR     = 6'd31,
		INV     = 6'd32,
		INV_M   = 6'd33,
		LAN     = 6'd34,    // Logical and, 0 or 1
		LOR     = 6'd35,
		LIN     = 6'd36,    // Logical not
		LIN_M   = 6'd37,
		LES     = 6'd38,    // Signed less than
		GRE     = 6'd40,
		EQU     = 6'd42,
		SHL     = 6'd43,
		SHR     = 6'd44,
		SRS     = 6'd45     // Arithmetic right shift
	} alu_op_e;

	// ******************************
	// Result units
	// ******************************

	// unit_none at zero so a cleared register means no result
	typedef enum logic [2:0] {
		unit_none  = 3'd0,
		unit_pass  = 3'd1,
		unit_arith = 3'd2,
		unit_logic = 3'd3,
		unit_cmp   = 3'd4,
		unit_shift = 3'd5
	} alu_unit_e;

endpackage

// File: src/alu_stage_if.sv
// Stage-to-stage bundles of the ALU pipeline
// Plain levels, one item per clock, no handshake

// ******************************
// Decode to execute
// ******************************

interface alu_issue_if import alu_pkg::*; ();

	alu_op_e   op;
	alu_unit_e unit;   // Unit that owns op
	alu_word_t a;      // in1
	alu_word_t b;      // in2
	alu_word_t u;      // Unary operand, in1 for _M forms

	modport src (output op, unit, a, b, u);
	modport dst (input  op, unit, a, b, u);

endinterface

// ******************************
// Execute to select
// ******************************

interface alu_result_if import alu_pkg::*; ();

	alu_unit_e unit;
	alu_word_t arith_res;
	alu_word_t logic_res;
	alu_word_t cmp_res;     // 0 or 1
	alu_word_t shift_res;
	alu_word_t pass_res;    // NOP / LOD

	modport src (output unit, arith_res, logic_res, cmp_res, shift_res, pass_res);
	modport dst (input  unit, arith_res, logic_res, cmp_res, shift_res, pass_res);

endinterface

// File: src/alu_decode_stage.sv
// First pipeline stage, samples op/in1/in2 on every rising edge
// Undefined opcodes map to unit_none and end up as a zero result

module alu_decode_stage import alu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	input  alu_op_e   op,
	input  alu_word_t in1,    // Memory operand
	input  alu_word_t in2,    // Accumulator operand
	alu_issue_if.src  issue
);

	alu_unit_e unit_next;
	logic      use_in1;       // Unary op works on in1

	// ******************************
	// Opcode class
	// ******************************

	always_comb begin
		case (op)
			NOP, LOD:
				unit_next = unit_pass;
			ADD, MLT, SGN, NEG, NEG_M, F_NEG, F_NEG_M,
			ABS, ABS_M, F_ABS, F_ABS_M, PST, PST_M, NRM, NRM_M:
				unit_next = unit_arith;
			AND, ORR, XOR, INV, INV_M, LAN, LOR, LIN, LIN_M:
				unit_next = unit_logic;
			LES, GRE, EQU:
				unit_next = unit_cmp;
			SHL, SHR, SRS:
				unit_next = unit_shift;
			default:
				unit_next = unit_none;   // Gap in the opcode map
		endcase
	end

	// The _M forms of the unary ops
	assign use_in1 = op inside {NEG_M, F_NEG_M, ABS_M, F_ABS_M, PST_M, NRM_M, INV_M, LIN_M};

	// ******************************
	// Issue register
	// ******************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			issue.op   <= NOP;
			issue.unit <= unit_none;
			issue.a    <= '0;
			issue.b    <= '0;
			issue.u    <= '0;
		end else begin
			issue.op   <= op;
			issue.unit <= unit_next;
			issue.a    <= in1;
			issue.b    <= in2;
			issue.u    <= use_in1 ? in1 : in2;
		end
	end

	// Undefined opcode reaches the output as zero, flag it anyway
	a_op_defined: assert property (@(posedge clk) disable iff (!rst_n)
		unit_next != unit_none)
		else $warning("Undefined opcode %0d issued", op);

endmodule

// File: src/alu_execute_stage.sv
// Second pipeline stage, all unit results computed in parallel
// NRM divides by nrm_gain and truncates toward zero
// Shift amount is the full in2 word, 32 or more shifts everything out

module alu_execute_stage import alu_pkg::*; #(
	parameter int nrm_gain = 64
) (
	input  logic      clk,
	input  logic      rst_n,
	alu_issue_if.dst  issue,
	alu_result_if.src res
);

	localparam alu_word_t nrm_div = alu_word_t'(nrm_gain);

	alu_word_t  arith_next;
	alu_word_t  logic_next;
	alu_word_t  cmp_next;
	alu_word_t  shift_next;
	alu_word_t  pass_next;
	logic       big_shift;    // Amount of 32 or more
	logic [4:0] sh_amt;

	// 0/1 flag as a full word
	function automatic alu_word_t to_word(input logic flag);
		return alu_word_t'({{(alu_w-1){1'b0}}, flag});
	endfunction

	// ******************************
	// Arithmetic
	// ******************************

	always_comb begin
		case (issue.op)
			ADD:            arith_next = issue.a + issue.b;   // Wraps
			MLT:            arith_next = issue.a * issue.b;   // Low 32 bits
			SGN:            arith_next = (issue.a[alu_w-1] == issue.b[alu_w-1]) ? issue.b : -issue.b;
			NEG, NEG_M:     arith_next = -issue.u;
			F_NEG, F_NEG_M: arith_next = {~issue.u[alu_w-1], issue.u[alu_w-2:0]};
			ABS, ABS_M:     arith_next = issue.u[alu_w-1] ? -issue.u : issue.u;
			F_ABS, F_ABS_M: arith_next = {1'b0, issue.u[alu_w-2:0]};
			PST, PST_M:     arith_next = issue.u[alu_w-1] ? '0 : issue.u;
			NRM, NRM_M:     arith_next = issue.u / nrm_div;   // Signed, toward zero
			default:        arith_next = '0;
		endcase
	end

	// ******************************
	// Bitwise and conditional
	// ******************************

	always_comb begin
		case (issue.op)
			AND:        logic_next = issue.a & issue.b;
			ORR:        logic_next = issue.a | issue.b;
			XOR:        logic_next = issue.a ^ issue.b;
			INV, INV_M: logic_next = ~issue.u;
			LAN:        logic_next = to_word((issue.a != '0) && (issue.b != '0));
			LOR:        logic_next = to_word((issue.a != '0) || (issue.b != '0));
			LIN, LIN_M: logic_next = to_word(issue.u == '0);
			default:    logic_next = '0;
		endcase
	end

	// ******************************
	// Compare and shift
	// ******************************

	always_comb begin
		case (issue.op)
			LES:     cmp_next = to_word(issue.a < issue.b);   // Signed operands
			GRE:     cmp_next = to_word(issue.a > issue.b);
			EQU:     cmp_next = to_word(issue.a == issue.b);
			default: cmp_next = '0;
		endcase
	end

	// Negative in2 counts as a huge amount
	assign big_shift = |issue.b[alu_w-1:5];
	assign sh_amt    = issue.b[4:0];

	always_comb begin
		case (issue.op)
			SHL:     shift_next = big_shift ? '0 : issue.a << sh_amt;
			SHR:     shift_next = big_shift ? '0 : issue.a >> sh_amt;
			SRS:     shift_next = issue.a >>> (big_shift ? 5'd31 : sh_amt);   // Sign fill when big
			default: shift_next = '0;
		endcase
	end

	assign pass_next = (issue.op == LOD) ? issue.a : issue.b;   // NOP keeps the accumulator

	// ******************************
	// Result register
	// ******************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			res.unit      <= unit_none;
			res.arith_res <= '0;
			res.logic_res <= '0;
			res.cmp_res   <= '0;
			res.shift_res <= '0;
			res.pass_res  <= '0;
		end else begin
			res.unit      <= issue.unit;   // Tag follows its data
			res.arith_res <= arith_next;
			res.logic_res <= logic_next;
			res.cmp_res   <= cmp_next;
			res.shift_res <= shift_next;
			res.pass_res  <= pass_next;
		end
	end

	a_gain_nonzero: assert property (@(posedge clk) nrm_gain != 0)
		else $error("NRM gain is zero");

endmodule

// File: src/alu_select_stage.sv
// Last pipeline stage, picks one unit result by its tag
// unit_none gives zero

module alu_select_stage import alu_pkg::*; (
	input  logic      clk,
	input  logic      rst_n,
	alu_result_if.dst res,
	output alu_word_t out
);

	alu_word_t out_next;

	always_comb begin
		case (res.unit)
			unit_pass:  out_next = res.pass_res;
			unit_arith: out_next = res.arith_res;
			unit_logic: out_next = res.logic_res;
			unit_cmp:   out_next = res.cmp_res;
			unit_shift: out_next = res.shift_res;
			default:    out_next = '0;   // Undefined opcode
		endcase
	end

	// ******************************
	// Output register
	// ******************************

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out <= '0;
		end else begin
			out <= out_next;
		end
	end

	// Clean inputs must give clean results through all three stages
	a_out_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(out))
		else $error("ALU output has unknown bits");

endmodule

// File: src/alu_pipe.sv
// Pipelined accumulator ALU, result appears three rising edges after issue
// A new operation may enter every clock, nothing stalls
// Undefined opcodes give zero

module alu_pipe import alu_pkg::*; #(
	parameter int nrm_gain = 64    // Divisor for NRM, must be nonzero
) (
	input  logic      clk,
	input  logic      rst_n,
	input  alu_op_e   op,
	input  alu_word_t in1,       // Memory operand
	input  alu_word_t in2,       // Accumulator operand
	output alu_word_t out
);

	// ******************************
	// Stage links
	// ******************************

	alu_issue_if  issue_if ();
	alu_result_if result_if ();

	// ******************************
	// Stages
	// ******************************

	alu_decode_stage decode_i (
		.clk   (clk),
		.rst_n (rst_n),
		.op    (op),
		.in1   (in1),
		.in2   (in2),
		.issue (issue_if.src)
	);

	alu_execute_stage #(
		.nrm_gain (nrm_gain)
	) execute_i (
		.clk   (clk),
		.rst_n (rst_n),
		.issue (issue_if.dst),
		.res   (result_if.src)
	);

	alu_select_stage select_i (
		.clk   (clk),
		.rst_n (rst_n),
		.res   (result_if.dst),
		.out   (out)
	);

endmodule

// File: tb/alu_clock_gen.sv
// Clock and reset source for the ALU testbench
// Period 100, reset low for the first 8 rising edges

module alu_clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;                 // Held from time zero
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;                // Released on a rising edge, seen at the falling one
	end

	always #50 clk = ~clk;            // Half period

endmodule

// File: tb/alu_pipe_tb.sv
// Testbench for the pipelined ALU, vectors come from tb/alu_testdata.txt
// One operation per clock, result checked on the falling edge three rising edges later
// An opcode word of ffffffff ends the vector list

module alu_pipe_tb import alu_pkg::*; ();

	localparam int max_ops        = 64;
	localparam int latency        = 3;     // Rising edges from drive to visible out
	localparam int timeout_cycles = 200;

	logic        clk;
	logic        rst_n;
	alu_op_e     op;
	alu_word_t   in1;
	alu_word_t   in2;
	alu_word_t   out;
	logic [31:0] vectors [0:4*max_ops-1];  // op, in1, in2, expected
	int          num_ops;
	int          cycle;                    // Rising edges since reset release
	int          checks;
	int          errors;
	alu_word_t   exp_q [$];
	alu_op_e     op_q [$];
	int          due_q [$];                // Cycle at which out holds the result

	alu_clock_gen clock_i (
		.clk   (clk),
		.rst_n (rst_n)
	);

	alu_pipe #(
		.nrm_gain (64)
	) alu_pipe_i (
		.clk   (clk),
		.rst_n (rst_n),
		.op    (op),
		.in1   (in1),
		.in2   (in2),
		.out   (out)
	);

	// ******************************
	// Checks
	// ******************************

	function automatic logic is_flag_op(input alu_op_e o);
		return o inside {LAN, LOR, LIN, LIN_M, LES, GRE, EQU};   // 0/1 results
	endfunction

	task automatic check_word(input alu_op_e o, input alu_word_t got, input alu_word_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("[FAIL] %0t op %0d %s: got %h, expected %h", $time, o, o.name(), got, exp);
		end
	endtask

	task automatic check_bool(input alu_op_e o, input alu_word_t got, input logic exp);
		checks++;
		if (got !== alu_word_t'({31'b0, exp})) begin
			errors++;
			$display("[FAIL] %0t op %0d %s: got %h, expected flag %b", $time, o, o.name(),
				got, exp);
		end
	endtask

	// Pops every item whose result is on out now
	task automatic check_due();
		alu_op_e   o;
		alu_word_t e;
		while (due_q.size() > 0 && due_q[0] == cycle) begin
			void'(due_q.pop_front());
			o = op_q.pop_front();
			e = exp_q.pop_front();
			if (is_flag_op(o))
				check_bool(o, out, e[0]);
			else
				check_word(o, out, e);
		end
	endtask

	task automatic fail_timeout(input string what);
		$display("Timeout while waiting for %s", what);
		$display("Regression failed");
		$finish;
	endtask

	// ******************************
	// Stimulus
	// ******************************

	task automatic wait_reset_release();
		int waited;
		waited = 0;
		while (!rst_n) begin
			if (waited >= timeout_cycles)
				fail_timeout("reset release");
			@(negedge clk);
			if (!rst_n)
				check_word(NOP, out, '0);   // Cleared pipe during reset
			waited++;
		end
	endtask

	task automatic drive_op(input alu_op_e o, input alu_word_t a, input alu_word_t b);
		@(posedge clk);
		cycle++;
		op  <= o;
		in1 <= a;
		in2 <= b;
	endtask

	initial begin
		op      = NOP;
		in1     = '0;
		in2     = '0;
		num_ops = 0;
		cycle   = 0;
		checks  = 0;
		errors  = 0;
		$readmemh("tb/alu_testdata.txt", vectors);
		while (num_ops < max_ops && vectors[4*num_ops] != 32'hffffffff)
			num_ops++;
		if (num_ops == 0) begin
			$display("No test vectors were loaded");
			errors++;
		end
		wait_reset_release();
		for (int i = 0; i < num_ops; i++) begin
			drive_op(alu_op_e'(vectors[4*i][5:0]), vectors[4*i+1], vectors[4*i+2]);
			op_q.push_back(alu_op_e'(vectors[4*i][5:0]));
			exp_q.push_back(vectors[4*i+3]);
			due_q.push_back(cycle + latency);
			@(negedge clk);
			check_due();
		end
		// Flush the last results with NOPs
		for (int waited = 0; due_q.size() > 0; waited++) begin
			if (waited >= timeout_cycles)
				fail_timeout("the result queue to drain");
			drive_op(NOP, '0, '0);
			@(negedge clk);
			check_due();
		end
		$display("Operations: %0d, checks: %0d, errors: %0d", num_ops, checks, errors);
		if (errors == 0 && num_ops > 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

// File: tb/alu_testdata.txt
// opcode in1 in2 expected, all hex, one operation per line
// opcode ffffffff ends the list
00000000 00000000 00000000 00000000
00000000 00000000 00000000 00000000
00000000 12345678 cafef00d cafef00d
00000001 12345678 cafef00d 12345678
00000002 ffffffff 00000002 00000001
00000004 00010001 00010001 00020001
00000009 80000000 00000005 fffffffb
00000009 fffffff0 fffffff3 fffffff3
0000000b 00000000 00000007 fffffff9
0000000c 00000003 00000000 fffffffd
0000000f 00000000 ffffff9c 00000064
00000010 ffffffff 00000000 00000001
00000013 00000000 ffffffff 00000000
00000014 00000042 ffffffff 00000042
00000017 00000000 ffffff9c ffffffff
00000018 00001000 00000000 00000040
0000000d 00000000 3f800000 bf800000
0000000e c0000000 00000000 40000000
00000011 00000000 bf800000 3f800000
00000012 ffffffff 00000000 7fffffff
0000001d f0f0f0f0 ff00ff00 f000f000
0000001e f0f0f0f0 0f0f0000 fffff0f0
0000001f aaaaaaaa ffff0000 5555aaaa
00000020 00000000 0000ffff ffff0000
00000021 12345678 00000000 edcba987
00000022 00000005 00000000 00000000
00000022 00000005 80000000 00000001
00000023 00000000 00000000 00000000
00000023 00000000 00000010 00000001
00000024 12345678 00000000 00000001
00000025 00000000 ffffffff 00000001
00000026 ffffffff 00000001 00000001
00000028 ffffffff 00000001 00000000
0000002a 13572468 13572468 00000001
00000003 12345678 9abcdef0 00000000
0000002b 00000001 0000001f 80000000
0000002c 80000000 0000001f 00000001
0000002d 80000000 00000004 f8000000
0000002b ffffffff 00000020 00000000
0000002d 80000000 00000040 ffffffff
ffffffff 00000000 00000000 00000000

// File: alu_pipe.f
src/alu_pkg.sv
src/alu_stage_if.sv
src/alu_decode_stage.sv
src/alu_execute_stage.sv
src/alu_select_stage.sv
src/alu_pipe.sv
tb/alu_clock_gen.sv
tb/alu_pipe_tb.sv

// File: Makefile
# Verilator build and run of the pipelined ALU testbench

TOP := alu_pipe_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -f alu_pipe.f -o $(TOP)

run: compile
	./obj_dir/$(TOP) > sim.log 2>&1 || true
	cat sim.log
	! grep -q "Regression failed" sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
